/* fpga_core.f */
logic/xgmii_pkg.sv
logic/xgmii_rx_decode.sv
logic/frame_engine.sv
logic/xgmii_tx_encode.sv
logic/fpga_core.sv
verif/fpga_core_props.sv
verif/tb_fpga_core.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; a non-zero exit means the run failed
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fpga_core -Mdir obj_dir -f fpga_core.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

# Let assertion errors reach the testbench, which then ends the run
./obj_dir/Vtb_fpga_core +verilator+error+limit+1000
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

/* verif/tb_fpga_core.sv */
// Loopback stimulus with seeded frames; word checks come from the bound props, counts from a model
`timescale 1ns/100ps

module tb_fpga_core import xgmii_pkg::*; ();

    localparam xgmii_word_t IDLE_WORD  = '{data: {CTRL_WIDTH{XGMII_IDLE}}, ctrl: '1};
    localparam xgmii_word_t ERROR_WORD = '{data: {CTRL_WIDTH{XGMII_ERROR}}, ctrl: '1};
    localparam int IDLE_TIMEOUT = 20;

    logic                   clk;
    logic                   reset;
    xgmii_word_t            rx;
    xgmii_word_t            tx;
    logic [1:0]             led;
    logic [COUNT_WIDTH-1:0] good_frames;
    logic [COUNT_WIDTH-1:0] bad_frames;

    // Expected counts from the framing rules
    logic [COUNT_WIDTH-1:0] exp_good;
    logic [COUNT_WIDTH-1:0] exp_bad;
    integer                 seed;
    string                  test_name;

    fpga_core i_fpga_core (
        .clk         (clk),
        .reset       (reset),
        .rx          (rx),
        .tx          (tx),
        .led         (led),
        .good_frames (good_frames),
        .bad_frames  (bad_frames)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (i_fpga_core.i_fpga_core_props.any_failed) begin
            $display("=== FAIL ===");
            $fatal(1, "a port assertion failed during test %s", test_name);
        end
    end

    function automatic logic [DATA_WIDTH-1:0] random_payload();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xgmii_word_t start_word();
        xgmii_word_t w;
        w.data      = random_payload();
        w.data[7:0] = XGMII_START;
        w.ctrl      = 8'h01;
        return w;
    endfunction

    function automatic xgmii_word_t data_word();
        xgmii_word_t w;
        w.data = random_payload();
        w.ctrl = '0;
        return w;
    endfunction

    // Lane-4 start decodes as malformed
    function automatic xgmii_word_t lane4_start_word();
        xgmii_word_t w;
        w.data        = random_payload();
        w.data[39:32] = XGMII_START;
        w.ctrl        = 8'h10;
        return w;
    endfunction

    function automatic xgmii_word_t term_word(input int lane);
        xgmii_word_t w;
        w.data = random_payload();
        w.ctrl = 8'hFF << lane;
        w.data[8*lane +: 8] = XGMII_TERM;
        for (int i = lane + 1; i < CTRL_WIDTH; i++) begin
            w.data[8*i +: 8] = XGMII_IDLE;
        end
        return w;
    endfunction

    task automatic drive_word(input xgmii_word_t w);
        @(negedge clk);
        rx = w;
    endtask

    task automatic send_idle(input int count);
        repeat (count) drive_word(IDLE_WORD);
    endtask

    // Nonzero corrupt injects an error word (1) or a lane-4 start (2) mid frame
    task automatic send_frame(input int len, input int lane, input int corrupt);
        int err_at;
        err_at = len / 2;
        drive_word(start_word());
        for (int i = 0; i < len; i++) begin
            if (corrupt != 0 && i == err_at) begin
                drive_word(corrupt == 1 ? ERROR_WORD : lane4_start_word());
            end else begin
                drive_word(data_word());
            end
        end
        drive_word(term_word(lane));
        if (corrupt != 0) begin
            exp_bad = exp_bad + 1'b1;
        end else begin
            exp_good = exp_good + 1'b1;
        end
    endtask

    // Engine back in idle means the last count update has landed
    task automatic wait_frame_idle(input int timeout);
        int cycles;
        cycles = 0;
        while (led[1] !== 1'b0) begin
            if (cycles == timeout) begin
                $display("=== FAIL ===");
                $fatal(1, "timeout waiting for the frame engine to leave its frame");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        int len;
        int lane;
        int corrupt;
        seed      = 41;
        exp_good  = '0;
        exp_bad   = '0;
        test_name = "reset";
        reset     = 1'b1;
        rx        = IDLE_WORD;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        send_idle(4);

        test_name = "term_lanes";
        for (int n = 0; n < CTRL_WIDTH; n++) begin
            len = 1 + int'($unsigned($random(seed)) % 6);
            send_frame(len, n, 0);
            send_idle(int'($unsigned($random(seed)) % 3));
        end

        test_name = "error_frames";
        send_frame(4, 2, 1);
        send_idle(2);
        send_frame(3, 7, 2);
        send_idle(1);

        // Second start closes the open frame as bad
        test_name = "start_without_term";
        drive_word(start_word());
        drive_word(data_word());
        drive_word(IDLE_WORD);
        drive_word(data_word());
        exp_bad = exp_bad + 1'b1;
        send_frame(3, 5, 0);
        send_idle(2);

        test_name = "stray_words";
        drive_word(term_word(3));
        exp_bad = exp_bad + 1'b1;
        drive_word(data_word());
        drive_word(lane4_start_word());
        send_idle(1);
        drive_word(term_word(0));
        exp_bad = exp_bad + 1'b1;
        drive_word(data_word());
        send_idle(2);

        test_name = "random_frames";
        for (int k = 0; k < 12; k++) begin
            len     = 1 + int'($unsigned($random(seed)) % 8);
            lane    = int'($unsigned($random(seed)) % 8);
            corrupt = int'($unsigned($random(seed)) % 3);
            send_frame(len, lane, corrupt);
            send_idle(int'($unsigned($random(seed)) % 4));
        end
        send_idle(PIPE_LATENCY + 2);

        test_name = "final_counts";
        wait_frame_idle(IDLE_TIMEOUT);
        if (i_fpga_core.i_fpga_core_props.any_failed) begin
            $display("=== FAIL ===");
            $fatal(1, "a port assertion failed during test %s", test_name);
        end else if (good_frames !== exp_good || bad_frames !== exp_bad ||
                     led[0] !== exp_good[0]) begin
            if (good_frames !== exp_good) begin
                $display("error: test %s good_frames expected %0d actual %0d",
                         test_name, exp_good, good_frames);
            end
            if (bad_frames !== exp_bad) begin
                $display("error: test %s bad_frames expected %0d actual %0d",
                         test_name, exp_bad, bad_frames);
            end
            // led[0] toggles once per good frame
            if (led[0] !== exp_good[0]) begin
                $display("error: test %s led[0] expected %0d actual %0d",
                         test_name, exp_good[0], led[0]);
            end
            $display("=== FAIL ===");
            $fatal(1, "frame counters or LED differ from the model");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

/* verif/fpga_core_props.sv */
// Port checks sampled on the rising clock; frames are tracked from rx words, lane-0 starts only
`timescale 1ns/100ps

module fpga_core_props import xgmii_pkg::*; (
    input logic                   clk,
    input logic                   reset,
    input xgmii_word_t            rx,
    input xgmii_word_t            tx,
    input logic [1:0]             led,
    input logic [COUNT_WIDTH-1:0] good_frames,
    input logic [COUNT_WIDTH-1:0] bad_frames
);

    localparam xgmii_word_t IDLE_WORD  = '{data: {CTRL_WIDTH{XGMII_IDLE}}, ctrl: '1};
    localparam xgmii_word_t ERROR_WORD = '{data: {CTRL_WIDTH{XGMII_ERROR}}, ctrl: '1};

    logic w_idle;
    logic w_start;
    logic w_data;
    logic w_term;
    logic in_frame;
    int   settle_cnt;
    logic settled;
    logic pass_through;
    logic to_idle;
    logic to_error;

    // Sticky flags read by the testbench
    logic pass_failed  = 1'b0;
    logic idle_failed  = 1'b0;
    logic error_failed = 1'b0;
    logic reset_failed = 1'b0;
    logic any_failed;

    // Lowest control lane holds the terminate, control set from there up, idle above
    function automatic logic is_term(xgmii_word_t w);
        int   lane;
        logic ok;
        lane = -1;
        for (int i = CTRL_WIDTH - 1; i >= 0; i--) begin
            if (w.ctrl[i]) begin
                lane = i;
            end
        end
        if (lane < 0) begin
            return 1'b0;
        end
        ok = (w.ctrl == (8'hFF << lane)) && (w.data[8*lane +: 8] == XGMII_TERM);
        for (int i = lane + 1; i < CTRL_WIDTH; i++) begin
            ok = ok && (w.data[8*i +: 8] == XGMII_IDLE);
        end
        return ok;
    endfunction

    assign w_idle   = (rx == IDLE_WORD);
    assign w_start  = (rx.ctrl == 8'h01) && (rx.data[7:0] == XGMII_START);
    assign w_data   = (rx.ctrl == '0);
    assign w_term   = is_term(rx);
    assign settled  = (settle_cnt == PIPE_LATENCY);
    assign pass_through = w_idle || w_start || (in_frame && (w_data || w_term));
    assign to_idle      = !in_frame && (w_data || w_term);
    assign to_error     = !(w_idle || w_start || w_data || w_term);
    assign any_failed   = pass_failed || idle_failed || error_failed || reset_failed;

    // Framing as seen at rx, errors keep a frame open
    always_ff @(posedge clk) begin
        if (reset) begin
            in_frame   <= 1'b0;
            settle_cnt <= 0;
        end else begin
            if (w_start) begin
                in_frame <= 1'b1;
            end else if (in_frame && w_term) begin
                in_frame <= 1'b0;
            end
            if (settle_cnt != PIPE_LATENCY) begin
                settle_cnt <= settle_cnt + 1;
            end
        end
    end

    a_pass_through: assert property (@(posedge clk) disable iff (reset)
        settled && $past(pass_through, PIPE_LATENCY) |-> tx == $past(rx, PIPE_LATENCY))
    else begin
        pass_failed = 1'b1;
        $error("tx does not repeat the rx word from %0d cycles earlier", PIPE_LATENCY);
    end

    a_stray_idle: assert property (@(posedge clk) disable iff (reset)
        settled && $past(to_idle, PIPE_LATENCY) |-> tx == IDLE_WORD)
    else begin
        idle_failed = 1'b1;
        $error("stray word outside a frame did not become the idle word");
    end

    a_malformed: assert property (@(posedge clk) disable iff (reset)
        settled && $past(to_error, PIPE_LATENCY) |-> tx == ERROR_WORD)
    else begin
        error_failed = 1'b1;
        $error("malformed word did not become the error word");
    end

    a_reset_state: assert property (@(posedge clk)
        reset |=> tx == IDLE_WORD && led == 2'b00 && good_frames == '0 && bad_frames == '0)
    else begin
        reset_failed = 1'b1;
        $error("outputs not at their reset values after reset");
    end

endmodule

bind fpga_core fpga_core_props i_fpga_core_props (.*);

/* logic/fpga_core.sv */
// Single SFP+ port in line loopback; rx and tx share the 156.25 MHz transmit clock
`timescale 1ns/100ps

module fpga_core import xgmii_pkg::*; (
    // 156.25 MHz, synchronous active-high reset
    input  logic                   clk,
    input  logic                   reset,

    // XGMII from and to the PHY
    input  xgmii_word_t            rx,
    output xgmii_word_t            tx,

    // Port status
    output logic [1:0]             led,
    output logic [COUNT_WIDTH-1:0] good_frames,
    output logic [COUNT_WIDTH-1:0] bad_frames
);

    // Decoded receive beats
    frame_beat_t rx_beat;

    // Beats checked by the frame engine
    frame_beat_t tx_beat;

    xgmii_rx_decode i_rx_decode (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx),
        .rx_beat (rx_beat)
    );

    frame_engine i_frame_engine (
        .clk         (clk),
        .reset       (reset),
        .rx_beat     (rx_beat),
        .tx_beat     (tx_beat),
        .led         (led),
        .good_frames (good_frames),
        .bad_frames  (bad_frames)
    );

    // Back to XGMII on the transmit side
    xgmii_tx_encode i_tx_encode (
        .clk     (clk),
        .reset   (reset),
        .tx_beat (tx_beat),
        .tx      (tx)
    );

endmodule

/* logic/xgmii_tx_encode.sv */
// Keep of a terminate beat must be contiguous from lane 0; output is the idle word during reset
`timescale 1ns/100ps

module xgmii_tx_encode import xgmii_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  frame_beat_t tx_beat,
    output xgmii_word_t tx
);

    localparam xgmii_word_t IDLE_WORD = '{data: {CTRL_WIDTH{XGMII_IDLE}}, ctrl: '1};

    xgmii_word_t word_next;

    always_comb begin : build_word
        logic term_placed;
        term_placed = 1'b0;
        word_next   = IDLE_WORD;
        case (tx_beat.kind)
            BEAT_IDLE: word_next = IDLE_WORD;
            BEAT_START: begin
                word_next.data = {tx_beat.data[DATA_WIDTH-1:8], XGMII_START};
                word_next.ctrl = 8'h01;
            end
            BEAT_DATA: begin
                word_next.data = tx_beat.data;
                word_next.ctrl = '0;
            end
            BEAT_TERM: begin
                for (int i = 0; i < CTRL_WIDTH; i++) begin
                    if (tx_beat.keep[i]) begin
                        word_next.data[8*i +: 8] = tx_beat.data[8*i +: 8];
                        word_next.ctrl[i]        = 1'b0;
                    end else if (!term_placed) begin
                        // First unkept lane carries the terminate
                        word_next.data[8*i +: 8] = XGMII_TERM;
                        word_next.ctrl[i]        = 1'b1;
                        term_placed              = 1'b1;
                    end else begin
                        word_next.data[8*i +: 8] = XGMII_IDLE;
                        word_next.ctrl[i]        = 1'b1;
                    end
                end
            end
            default: begin
                // Error beat and unused kinds
                word_next.data = {CTRL_WIDTH{XGMII_ERROR}};
                word_next.ctrl = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx <= IDLE_WORD;
        end else begin
            tx <= word_next;
        end
    end

endmodule

/* logic/frame_engine.sv */
// Counters wrap at COUNT_WIDTH; no CRC check, so a frame is good when it carries no error beat
`timescale 1ns/100ps

module frame_engine import xgmii_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  frame_beat_t            rx_beat,
    output frame_beat_t            tx_beat,
    output logic [1:0]             led,
    output logic [COUNT_WIDTH-1:0] good_frames,
    output logic [COUNT_WIDTH-1:0] bad_frames
);

    frame_state_e state;
    frame_state_e state_next;
    logic         frame_err;
    logic         frame_err_next;
    logic         count_good;
    logic         count_bad;
    logic         good_toggle;
    frame_beat_t  beat_next;

    always_comb begin
        beat_next      = rx_beat;
        state_next     = state;
        frame_err_next = frame_err;
        count_good     = 1'b0;
        count_bad      = 1'b0;
        case (state)
            FRAME_IDLE: begin
                case (rx_beat.kind)
                    BEAT_START: begin
                        state_next     = FRAME_ACTIVE;
                        frame_err_next = 1'b0;
                    end
                    // Stray data is dropped silently
                    BEAT_DATA: beat_next.kind = BEAT_IDLE;
                    BEAT_TERM: begin
                        beat_next.kind = BEAT_IDLE;
                        count_bad      = 1'b1;
                    end
                    default: ;
                endcase
            end
            FRAME_ACTIVE: begin
                case (rx_beat.kind)
                    // New start closes the old frame as bad
                    BEAT_START: begin
                        count_bad      = 1'b1;
                        frame_err_next = 1'b0;
                    end
                    BEAT_ERROR: frame_err_next = 1'b1;
                    BEAT_TERM: begin
                        state_next = FRAME_IDLE;
                        count_good = !frame_err;
                        count_bad  = frame_err;
                    end
                    default: ;
                endcase
            end
        endcase
    end

    // Control state and counters
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= FRAME_IDLE;
            frame_err   <= 1'b0;
            good_toggle <= 1'b0;
            good_frames <= '0;
            bad_frames  <= '0;
        end else begin
            state     <= state_next;
            frame_err <= frame_err_next;
            if (count_good) begin
                good_frames <= good_frames + 1'b1;
                good_toggle <= !good_toggle;
            end
            if (count_bad) begin
                bad_frames <= bad_frames + 1'b1;
            end
        end
    end

    // Forwarded beat register
    always_ff @(posedge clk) begin
        tx_beat.data <= beat_next.data;
        tx_beat.keep <= beat_next.keep;
        if (reset) begin
            tx_beat.kind <= BEAT_IDLE;
        end else begin
            tx_beat.kind <= beat_next.kind;
        end
    end

    // led[1] shows an open frame
    assign led = {state == FRAME_ACTIVE, good_toggle};

endmodule

/* logic/xgmii_rx_decode.sv */
// Only a start in lane 0 is accepted; any other control pattern decodes as an error beat
`timescale 1ns/100ps

module xgmii_rx_decode import xgmii_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  xgmii_word_t rx,
    output frame_beat_t rx_beat
);

    // Lanes carrying the idle character with their control bit set
    logic [CTRL_WIDTH-1:0] idle_lane;
    logic                  all_idle;
    logic                  term_hit;
    logic [CTRL_WIDTH-1:0] term_keep;
    frame_beat_t           beat_next;

    always_comb begin
        for (int i = 0; i < CTRL_WIDTH; i++) begin
            idle_lane[i] = rx.ctrl[i] && (rx.data[8*i +: 8] == XGMII_IDLE);
        end
    end

    assign all_idle = &idle_lane;

    // Terminate search over all eight lanes
    always_comb begin : term_search
        logic [CTRL_WIDTH-1:0] term_ctrl;
        logic [CTRL_WIDTH-1:0] above;
        term_hit  = 1'b0;
        term_keep = '0;
        for (int n = 0; n < CTRL_WIDTH; n++) begin
            // Control bits n and up set, lanes strictly above n must be idle
            term_ctrl = {CTRL_WIDTH{1'b1}} << n;
            above     = term_ctrl;
            above[n]  = 1'b0;
            if (rx.ctrl == term_ctrl && rx.data[8*n +: 8] == XGMII_TERM &&
                    (idle_lane & above) == above) begin
                term_hit  = 1'b1;
                term_keep = ~term_ctrl;
            end
        end
    end

    // Classify the word
    always_comb begin
        beat_next.kind = BEAT_ERROR;
        beat_next.data = rx.data;
        beat_next.keep = '0;
        if (rx.ctrl == '0) begin
            beat_next.kind = BEAT_DATA;
            beat_next.keep = '1;
        end else if (all_idle) begin
            beat_next.kind = BEAT_IDLE;
        end else if (rx.ctrl == 8'h01 && rx.data[7:0] == XGMII_START) begin
            // Lane 0 holds the start, the rest is payload
            beat_next.kind = BEAT_START;
            beat_next.keep = 8'hFE;
        end else if (term_hit) begin
            beat_next.kind = BEAT_TERM;
            beat_next.keep = term_keep;
        end
    end

    always_ff @(posedge clk) begin
        rx_beat.data <= beat_next.data;
        rx_beat.keep <= beat_next.keep;
        if (reset) begin
            rx_beat.kind <= BEAT_IDLE;
        end else begin
            rx_beat.kind <= beat_next.kind;
        end
    end

endmodule

/* logic/xgmii_pkg.sv */
// Shared XGMII types and constants; only 64-bit XGMII with lane-0 starts is covered
package xgmii_pkg;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    // Bus widths, one control bit per byte lane
    localparam int DATA_WIDTH = 64;
    localparam int CTRL_WIDTH = 8;

    // Frame counters wrap at this width
    localparam int COUNT_WIDTH = 16;

    // rx to tx delay in clock cycles, one per module
    localparam int PIPE_LATENCY = 3;

    // One XGMII word as seen on the PHY interface
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [CTRL_WIDTH-1:0] ctrl;
    } xgmii_word_t;

    // Beat classes after decode
    typedef enum logic [2:0] {
        BEAT_IDLE,
        BEAT_START,
        BEAT_DATA,
        BEAT_TERM,
        BEAT_ERROR
    } beat_kind_e;

    // Keep marks valid lanes of a terminate beat
    typedef struct packed {
        beat_kind_e            kind;
        logic [DATA_WIDTH-1:0] data;
        logic [CTRL_WIDTH-1:0] keep;
    } frame_beat_t;

    typedef enum logic {
        FRAME_IDLE,
        FRAME_ACTIVE
    } frame_state_e;

endpackage
